// File: rtl/fetch_pkg.sv
package fetch_pkg;

    // Cache line geometry
    localparam int CACHE_LINE_SIZE = 128;
    localparam int LINE_WORDS      = CACHE_LINE_SIZE / 32;
    localparam int ICACHE_LINES    = 16;

    // Physical address split for the icache
    localparam int OFFSET_BITS = $clog2(CACHE_LINE_SIZE / 8);
    localparam int INDEX_BITS  = $clog2(ICACHE_LINES);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

    // Fixed program addresses
    localparam logic [31:0] INIT_ADDR    = 32'h1000;
    localparam logic [31:0] HANDLER_ADDR = 32'h0100;

    // Paging
    localparam int PAGE_BITS     = 12;
    localparam int VPN_BITS      = 32 - PAGE_BITS;
    localparam int ITLB_ENTRIES  = 4;
    localparam int ITLB_IDX_BITS = $clog2(ITLB_ENTRIES);

    // Slot 3 of the privileged file is reserved
    localparam int PRIV_REG_COUNT = 5;

    // Exception causes reported by the ROB and by fetch
    typedef enum logic [2:0] {
        EXC_NONE     = 3'd0,
        EXC_ITLBMISS = 3'd1,
        EXC_DTLBMISS = 3'd2,
        EXC_ILLEGAL  = 3'd3,
        EXC_SYSCALL  = 3'd4
    } exception_e;

    // Privileged register indices
    typedef enum logic [2:0] {
        PRIV_EPC        = 3'd0,
        PRIV_FAULT_ADDR = 3'd1,
        PRIV_CAUSE      = 3'd2,
        PRIV_STATUS     = 3'd4
    } priv_reg_e;

    // Icache line-fill FSM
    typedef enum logic {
        CACHE_IDLE,
        CACHE_FILL
    } icache_state_e;

endpackage

// File: rtl/privileged_regs.sv
`timescale 1ns/10ps

module privileged_regs (
    input  logic                  clk,
    input  logic                  reset,

    // Register write from the ROB
    input  fetch_pkg::priv_reg_e  rm_idx,
    input  logic                  write_enable,
    input  logic [31:0]           write_data,

    // Fault report
    input  fetch_pkg::exception_e exception_vector,
    input  logic [31:0]           fault_pc,
    input  logic [31:0]           fault_addr,

    output logic [31:0]           new_address,
    output logic                  overwrite_pc,
    output logic                  supervisor_mode,
    output logic [31:0]           rm1
);
    import fetch_pkg::*;

    logic [31:0] regs [PRIV_REG_COUNT];
    logic        fault_valid;

    assign fault_valid = exception_vector != EXC_NONE;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < PRIV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            // Come out of reset in supervisor mode
            regs[PRIV_STATUS] <= 32'd1;
            overwrite_pc      <= 1'b0;
        end else begin
            overwrite_pc <= fault_valid;

            if (write_enable) begin
                regs[rm_idx] <= write_data;
            end

            // A fault overrides a write in the same cycle
            if (fault_valid) begin
                regs[PRIV_EPC]        <= fault_pc;
                regs[PRIV_FAULT_ADDR] <= fault_addr;
                regs[PRIV_CAUSE]      <= {29'b0, exception_vector};
                regs[PRIV_STATUS][0]  <= 1'b1;
            end
        end
    end

    assign supervisor_mode = regs[PRIV_STATUS][0];
    assign rm1             = regs[PRIV_FAULT_ADDR];

    // Redirect target is always the single handler entry
    assign new_address = HANDLER_ADDR;

    // The ROB never reports faults on two consecutive cycles
    a_single_redirect: assert property (
        @(posedge clk) disable iff (reset)
        overwrite_pc |=> !overwrite_pc
    );

endmodule

// File: rtl/itlb.sv
`timescale 1ns/10ps

module itlb (
    input  logic        clk,
    input  logic        reset,
    input  logic        supervisor_mode,
    input  logic [31:0] virtual_address,

    // Refill port
    input  logic        write_enable,
    input  logic [31:0] write_virtual_address,
    input  logic [31:0] write_physical_address,

    output logic [31:0] physical_address,
    output logic        hit
);
    import fetch_pkg::*;

    logic [ITLB_ENTRIES-1:0]  valid;
    logic [VPN_BITS-1:0]      vpn [ITLB_ENTRIES];
    logic [VPN_BITS-1:0]      ppn [ITLB_ENTRIES];
    logic [ITLB_IDX_BITS-1:0] victim;

    logic [VPN_BITS-1:0]      lookup_vpn;
    logic [VPN_BITS-1:0]      fill_vpn;
    logic [VPN_BITS-1:0]      match_ppn;
    logic                     match;
    logic                     fill_found;
    logic [ITLB_IDX_BITS-1:0] fill_slot;

    assign lookup_vpn = virtual_address[31:PAGE_BITS];
    assign fill_vpn   = write_virtual_address[31:PAGE_BITS];

    // Fully associative compare
    always_comb begin
        match     = 1'b0;
        match_ppn = '0;
        for (int i = 0; i < ITLB_ENTRIES; i++) begin
            if (valid[i] && vpn[i] == lookup_vpn) begin
                match     = 1'b1;
                match_ppn = ppn[i];
            end
        end
    end

    // Reuse an entry holding the same page, else take the round-robin victim
    always_comb begin
        fill_found = 1'b0;
        fill_slot  = victim;
        for (int i = 0; i < ITLB_ENTRIES; i++) begin
            if (valid[i] && vpn[i] == fill_vpn) begin
                fill_found = 1'b1;
                fill_slot  = ITLB_IDX_BITS'(i);
            end
        end
    end

    // No translation in supervisor mode
    assign hit              = supervisor_mode || match;
    assign physical_address = supervisor_mode ? virtual_address :
                              {match_ppn, virtual_address[PAGE_BITS-1:0]};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid  <= '0;
            victim <= '0;
        end else if (write_enable) begin
            valid[fill_slot] <= 1'b1;
            if (!fill_found) begin
                victim <= victim + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            vpn[fill_slot] <= fill_vpn;
            ppn[fill_slot] <= write_physical_address[31:PAGE_BITS];
        end
    end

    for (genvar i = 0; i < ITLB_ENTRIES; i++) begin : g_unique_i
        for (genvar j = i + 1; j < ITLB_ENTRIES; j++) begin : g_unique_j
            a_unique_vpn: assert property (
                @(posedge clk) disable iff (reset)
                !(valid[i] && valid[j] && vpn[i] == vpn[j])
            );
        end
    end

endmodule

// File: rtl/icache.sv
`timescale 1ns/10ps

module icache (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                tlb_hit,
    input  logic [31:0]                         addr,

    // Line return from memory
    input  logic [fetch_pkg::CACHE_LINE_SIZE-1:0] mem_read_data,
    input  logic                                mem_ready,

    output logic [31:0]                         read_data,
    output logic                                busy,
    output logic                                mem_read_en,
    output logic [31:0]                         mem_addr
);
    import fetch_pkg::*;

    // Line storage
    logic [CACHE_LINE_SIZE-1:0] data_mem [ICACHE_LINES];
    logic [TAG_BITS-1:0]        tag_mem  [ICACHE_LINES];
    logic [ICACHE_LINES-1:0]    valid;

    icache_state_e state;
    logic [31:0]   fill_addr;

    logic [INDEX_BITS-1:0]      index;
    logic [INDEX_BITS-1:0]      fill_index;
    logic [TAG_BITS-1:0]        tag;
    logic [LINE_WORDS-1:0][31:0] line_words;
    logic                       cache_hit;
    logic                       start_fill;
    logic                       line_done;

    assign index      = addr[OFFSET_BITS +: INDEX_BITS];
    assign tag        = addr[31 -: TAG_BITS];
    assign fill_index = fill_addr[OFFSET_BITS +: INDEX_BITS];

    // Combinational hit path
    assign cache_hit  = valid[index] && tag_mem[index] == tag;
    assign line_words = data_mem[index];
    assign read_data  = line_words[addr[OFFSET_BITS-1:2]];

    // Only a translated miss stalls fetch
    assign busy = tlb_hit && !cache_hit;

    assign start_fill = state == CACHE_IDLE && busy;
    assign line_done  = state == CACHE_FILL && mem_ready;

    assign mem_read_en = state == CACHE_FILL;
    assign mem_addr    = fill_addr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= CACHE_IDLE;
            valid <= '0;
        end else begin
            case (state)
                CACHE_IDLE: begin
                    if (start_fill) begin
                        state <= CACHE_FILL;
                    end
                end
                CACHE_FILL: begin
                    // Fill runs to completion even if the PC moved away
                    if (mem_ready) begin
                        state             <= CACHE_IDLE;
                        valid[fill_index] <= 1'b1;
                    end
                end
                default: begin
                    state <= CACHE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            fill_addr <= {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
        if (line_done) begin
            data_mem[fill_index] <= mem_read_data;
            tag_mem[fill_index]  <= fill_addr[31 -: TAG_BITS];
        end
    end

    // Request held with a steady address until the line arrives
    a_request_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_read_en && !mem_ready |=> mem_read_en && $stable(mem_addr)
    );

    // Memory answers only an open request
    a_ready_in_fill: assert property (
        @(posedge clk) disable iff (reset)
        mem_ready |-> state == CACHE_FILL
    );

endmodule

// File: rtl/stage_fetch.sv
`timescale 1ns/10ps

module stage_fetch (
    input  logic                                  clk,
    input  logic                                  reset,

    // Redirect and freeze
    input  logic                                  branch_taken,
    input  logic [31:0]                           new_pc,
    input  logic                                  pc_write_disable,
    input  logic                                  d_cache_stall,

    // Fault report from the ROB
    input  fetch_pkg::exception_e                 exception_vector,
    input  logic [31:0]                           rob_fault_pc,
    input  logic [31:0]                           rob_fault_addr,

    // Privileged register write
    input  logic                                  priv_write_enable,
    input  fetch_pkg::priv_reg_e                  priv_rm_idx,
    input  logic [31:0]                           priv_write_data,

    // ITLB fill
    input  logic                                  itlb_write_enable,
    input  logic [31:0]                           tlb_virtual_address,
    input  logic [31:0]                           tlb_physical_address,

    // Memory line return
    input  logic [fetch_pkg::CACHE_LINE_SIZE-1:0] mem_read_data,
    input  logic                                  mem_ready,

    output logic [31:0]                           pc,
    output logic [31:0]                           instruction,
    output logic                                  stall,
    output fetch_pkg::exception_e                 out_exception_vector,
    output logic                                  mem_read_en,
    output logic [31:0]                           mem_addr,
    output logic [31:0]                           rm1
);
    import fetch_pkg::*;

    logic        supervisor_mode;
    logic        overwrite_pc;
    logic [31:0] overwrite_pc_addr;
    logic [31:0] physical_address;
    logic        itlb_hit;
    logic [31:0] cache_instr;
    logic [31:0] next_pc;
    logic        pc_frozen;

    // Branch beats the exception redirect, which beats sequential fetch
    always_comb begin
        if (branch_taken) begin
            next_pc = new_pc;
        end else if (overwrite_pc) begin
            next_pc = overwrite_pc_addr;
        end else if (!stall) begin
            next_pc = pc + 32'd4;
        end else begin
            next_pc = pc;
        end
    end

    assign pc_frozen = pc_write_disable || d_cache_stall;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= INIT_ADDR;
        end else if (!pc_frozen) begin
            pc <= next_pc;
        end
    end

    privileged_regs privileged_regs0 (
        .clk              (clk),
        .reset            (reset),
        .rm_idx           (priv_rm_idx),
        .write_enable     (priv_write_enable),
        .write_data       (priv_write_data),
        .exception_vector (exception_vector),
        .fault_pc         (rob_fault_pc),
        .fault_addr       (rob_fault_addr),
        .new_address      (overwrite_pc_addr),
        .overwrite_pc     (overwrite_pc),
        .supervisor_mode  (supervisor_mode),
        .rm1              (rm1)
    );

    itlb itlb0 (
        .clk                    (clk),
        .reset                  (reset),
        .supervisor_mode        (supervisor_mode),
        .virtual_address        (pc),
        .write_enable           (itlb_write_enable),
        .write_virtual_address  (tlb_virtual_address),
        .write_physical_address (tlb_physical_address),
        .physical_address       (physical_address),
        .hit                    (itlb_hit)
    );

    icache icache0 (
        .clk           (clk),
        .reset         (reset),
        .tlb_hit       (itlb_hit),
        .addr          (physical_address),
        .mem_read_data (mem_read_data),
        .mem_ready     (mem_ready),
        .read_data     (cache_instr),
        .busy          (stall),
        .mem_read_en   (mem_read_en),
        .mem_addr      (mem_addr)
    );

    // Output mux
    assign instruction          = itlb_hit ? cache_instr : 32'h0;
    assign out_exception_vector = itlb_hit ? EXC_NONE : EXC_ITLBMISS;

    // Handler fetch always runs untranslated
    a_handler_untranslated: assert property (
        @(posedge clk) disable iff (reset)
        overwrite_pc |-> itlb_hit
    );

endmodule

// File: testbench/main_memory_model.sv
`timescale 1ns/10ps

module main_memory_model #(
    parameter int          LATENCY = 3,
    parameter logic [31:0] PATTERN = 32'h0
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  read_en,
    input  logic [31:0]                           addr,
    output logic [fetch_pkg::CACHE_LINE_SIZE-1:0] read_data,
    output logic                                  ready
);
    import fetch_pkg::*;

    int count;

    // Every word is its own byte address scrambled by the pattern
    function automatic logic [CACHE_LINE_SIZE-1:0] build_line(input logic [31:0] base);
        logic [CACHE_LINE_SIZE-1:0] line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i*32 +: 32] = (base + 32'(4 * i)) ^ PATTERN;
        end
        return line;
    endfunction

    // Answers on falling edges, ready is seen at the next rising edge
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            count     <= 0;
            ready     <= 1'b0;
            read_data <= '0;
        end else if (ready || !read_en) begin
            count <= 0;
            ready <= 1'b0;
        end else if (count == LATENCY - 1) begin
            count     <= 0;
            ready     <= 1'b1;
            read_data <= build_line(addr);
        end else begin
            count <= count + 1;
        end
    end

endmodule

// File: testbench/tb_stage_fetch.sv
`timescale 1ns/10ps

module tb_stage_fetch;
    import fetch_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 3;
    localparam int          MEM_LATENCY  = 3;
    localparam logic [31:0] PATTERN      = 32'h5a3c96e1;
    localparam logic [31:0] LFSR_SEED    = 32'hb268ebd2;
    localparam logic [31:0] LFSR_TAPS    = 32'h80200003;
    localparam int          SEQ_CYCLES   = 24;
    localparam int          BRANCHES     = 12;
    localparam int          RUN_CYCLES   = 12;
    // A step is at most a few waits, a freeze and two line fills
    localparam int MISS_CYCLES    = MEM_LATENCY + 3;
    localparam int CYCLE_BUDGET   = RESET_CYCLES + SEQ_CYCLES + BRANCHES * (12 + 2 * MISS_CYCLES)
                                    + 6 * (RUN_CYCLES + MISS_CYCLES);
    localparam int TIMEOUT_CYCLES = 2 * CYCLE_BUDGET;

    logic clk, reset, branch_taken, pc_write_disable, d_cache_stall;
    logic priv_write_enable, itlb_write_enable, mem_ready, stall, mem_read_en;
    logic [31:0] new_pc, rob_fault_pc, rob_fault_addr, priv_write_data;
    logic [31:0] tlb_virtual_address, tlb_physical_address;
    logic [31:0] pc, instruction, mem_addr, rm1;
    logic [CACHE_LINE_SIZE-1:0] mem_read_data;
    exception_e exception_vector, out_exception_vector, exp_exc;
    priv_reg_e priv_rm_idx;

    // Reference state of mode and mapping, updated one half cycle after the DUT
    logic supervisor, map_valid, mapped, expect_hit;
    logic [VPN_BITS-1:0] map_vpn, map_ppn;
    logic [31:0] exp_phys, exp_line, exp_instr, lfsr;
    int errors = 0;
    int cycles = 0;

    stage_fetch dut0 (.*);

    main_memory_model #(.LATENCY(MEM_LATENCY), .PATTERN(PATTERN)) mem0 (
        .clk       (clk),
        .reset     (reset),
        .read_en   (mem_read_en),
        .addr      (mem_addr),
        .read_data (mem_read_data),
        .ready     (mem_ready)
    );

    always_comb begin
        mapped    = map_valid && pc[31:PAGE_BITS] == map_vpn;
        exp_phys  = supervisor ? pc : {map_ppn, pc[PAGE_BITS-1:0]};
        exp_line  = {exp_phys[31:4], 4'h0};
        exp_instr = (supervisor || mapped) ? exp_phys ^ PATTERN : 32'h0;
        exp_exc   = (supervisor || mapped) ? EXC_NONE : EXC_ITLBMISS;
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with stimulus still running", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic log_mismatch(input string what);
        errors++;
        $display("Mismatch at %0t: %s", $time, what);
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < count; i++) begin
            bit_out = lfsr[0];
            lfsr    = (lfsr >> 1) ^ (bit_out ? LFSR_TAPS : 32'h0);
            value   = {value[30:0], bit_out};
        end
        return value;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_no_stall();
        while (stall) @(negedge clk);
    endtask

    task automatic branch_to(input logic [31:0] target);
        branch_taken = 1'b1;
        new_pc       = target;
        @(negedge clk);
        branch_taken = 1'b0;
    endtask

    task automatic freeze(input int len, input logic use_dcache);
        if (use_dcache) d_cache_stall = 1'b1;
        else pc_write_disable = 1'b1;
        wait_cycles(len);
        d_cache_stall    = 1'b0;
        pc_write_disable = 1'b0;
    endtask

    task automatic write_status(input logic [31:0] value);
        priv_write_enable = 1'b1;
        priv_rm_idx       = PRIV_STATUS;
        priv_write_data   = value;
        @(negedge clk);
        priv_write_enable = 1'b0;
        supervisor        = value[0];
    endtask

    task automatic fill_tlb(input logic [31:0] vaddr, input logic [31:0] paddr);
        itlb_write_enable    = 1'b1;
        tlb_virtual_address  = vaddr;
        tlb_physical_address = paddr;
        @(negedge clk);
        itlb_write_enable = 1'b0;
        map_valid         = 1'b1;
        map_vpn           = vaddr[31:PAGE_BITS];
        map_ppn           = paddr[31:PAGE_BITS];
    endtask

    task automatic report_fault(input exception_e cause, input logic [31:0] fault_addr);
        exception_vector = cause;
        rob_fault_pc     = pc;
        rob_fault_addr   = fault_addr;
        @(negedge clk);
        exception_vector = EXC_NONE;
        supervisor       = 1'b1;
    endtask

    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> pc == INIT_ADDR && !mem_read_en
    ) else log_mismatch("pc or memory request wrong after reset");

    a_advance: assert property (@(posedge clk) disable iff (reset)
        !stall && !pc_write_disable && !d_cache_stall && !branch_taken &&
            $past(exception_vector) == EXC_NONE
        |=> pc == $past(pc) + 32'd4
    ) else log_mismatch("pc did not advance by 4");

    a_hold: assert property (@(posedge clk) disable iff (reset)
        pc_write_disable || d_cache_stall ||
            (stall && !branch_taken && $past(exception_vector) == EXC_NONE)
        |=> pc == $past(pc)
    ) else log_mismatch("pc moved while stalled or frozen");

    a_branch: assert property (@(posedge clk) disable iff (reset)
        branch_taken && !pc_write_disable && !d_cache_stall |=> pc == $past(new_pc)
    ) else log_mismatch("pc did not load the branch target");

    a_redirect: assert property (@(posedge clk) disable iff (reset)
        $past(exception_vector) != EXC_NONE && !branch_taken && !pc_write_disable &&
            !d_cache_stall
        |=> pc == HANDLER_ADDR
    ) else log_mismatch("pc did not reach the handler address");

    a_fault_addr: assert property (@(posedge clk) disable iff (reset)
        $past(exception_vector) != EXC_NONE |-> rm1 == $past(rob_fault_addr)
    ) else log_mismatch("rm1 does not hold the reported fault address");

    a_instr: assert property (@(posedge clk) disable iff (reset)
        !stall |-> instruction == exp_instr
    ) else log_mismatch("wrong instruction word");

    a_exception: assert property (@(posedge clk) disable iff (reset)
        out_exception_vector == exp_exc
    ) else log_mismatch("wrong fetch exception");

    a_fill_addr: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_read_en) |-> mem_addr == $past(exp_line)
    ) else log_mismatch("line request address is not the aligned fetch address");

    a_refetch: assert property (@(posedge clk) disable iff (reset)
        expect_hit |-> !stall
    ) else log_mismatch("refetch of a cached line stalled");

    initial begin
        logic [31:0] pick;
        int          len;
        lfsr = LFSR_SEED;
        reset = 1'b1;
        branch_taken = 1'b0;
        new_pc = '0;
        pc_write_disable = 1'b0;
        d_cache_stall = 1'b0;
        exception_vector = EXC_NONE;
        rob_fault_pc = '0;
        rob_fault_addr = '0;
        priv_write_enable = 1'b0;
        priv_rm_idx = PRIV_EPC;
        priv_write_data = '0;
        itlb_write_enable = 1'b0;
        tlb_virtual_address = '0;
        tlb_physical_address = '0;
        supervisor = 1'b1;
        map_valid = 1'b0;
        map_vpn = '0;
        map_ppn = '0;
        expect_hit = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        wait_cycles(SEQ_CYCLES);
        // First line of the program is still resident
        wait_no_stall();
        branch_to(INIT_ADDR);
        expect_hit = 1'b1;
        @(negedge clk);
        expect_hit = 1'b0;

        // Targets stay in the lower half of page 1
        for (int i = 0; i < BRANCHES; i++) begin
            wait_no_stall();
            pick = random_bits(9);
            branch_to({20'h00001, 1'b0, pick[8:0], 2'b00});
            wait_cycles(random_bits(2) + 1);
            len  = random_bits(2) + 1;
            pick = random_bits(1);
            freeze(len, pick[0]);
        end

        // Translation on with nothing mapped, then map and remap the page
        wait_no_stall();
        write_status(32'h0);
        wait_cycles(4);
        pick = random_bits(VPN_BITS);
        fill_tlb(pc, {pick[VPN_BITS-1:0], 12'h000});
        wait_cycles(RUN_CYCLES);
        pick = random_bits(VPN_BITS);
        fill_tlb(pc, {pick[VPN_BITS-1:0], 12'h000});
        wait_cycles(RUN_CYCLES);

        wait_no_stall();
        report_fault(EXC_ILLEGAL, random_bits(32));
        wait_cycles(RUN_CYCLES);

        // Branch lands in the redirect cycle
        wait_no_stall();
        report_fault(EXC_SYSCALL, random_bits(32));
        branch_to(INIT_ADDR + 32'h40);
        wait_cycles(RUN_CYCLES);
        wait_no_stall();
        wait_cycles(2);

        $display("Summary: %0d cycles run, %0d assertion failures", cycles, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/fetch_pkg.sv
rtl/privileged_regs.sv
rtl/itlb.sv
rtl/icache.sv
rtl/stage_fetch.sv
testbench/main_memory_model.sv
testbench/tb_stage_fetch.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_stage_fetch -f sources.f

out=$(./obj_dir/Vtb_stage_fetch 2>&1) || {
    printf '%s\n' "$out"
    exit 1
}
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test passed'
